//--- qdec_link.f
+incdir+dv
logic/qdec_pkg.sv
logic/fifo_fwft.sv
logic/pu_arbitration_unit.sv
logic/pu_link_top.sv
dv/tb_pu_link.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pu_link
FILELIST  ?= qdec_link.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) dv/tb_pu_link_tasks.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_pu_link_tasks.svh
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "value mismatch");
    end
endtask

task automatic fail_now(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "check failed");
endtask

function automatic neighbor_msg_t random_neighbor();
    logic [31:0] r;
    r = $random(seed);
    return r[$bits(neighbor_msg_t)-1:0];
endfunction

function automatic direct_msg_t random_direct();
    logic [31:0] r;
    r = $random(seed);
    return r[$bits(direct_msg_t)-1:0];
endfunction

// words still waiting at a source or not yet delivered
function automatic int pending_words();
    return q_src_a_nb.size() + q_src_a_dir.size() + q_src_b_nb.size() + q_src_b_dir.size() +
           q_exp_a_nb.size() + q_exp_a_dir.size() + q_exp_b_nb.size() + q_exp_b_dir.size();
endfunction

// returns on a rising edge with every queue empty and the link quiet
task automatic wait_drained();
    do @(negedge clk);
    while (pending_words() > 0 || has_flying_messages);
    @(posedge clk);
endtask

task automatic reset_outputs_quiet();
    @(negedge clk);
    check_value("sink valids", 32'(in_valid), 32'h0);
    check_value("has_flying_messages", 32'(has_flying_messages), 32'h0);
    check_value("send readies", 32'(out_ready), 32'hf);
    @(posedge clk);
endtask

task automatic neighbor_path_a_to_b();
    int seen_before;
    seen_before = valid_seen[3];
    q_src_a_nb.push_back(random_neighbor());
    wait_drained();
    check_value("b_neighbor_in latency", 32'(deliver_cycle[2] - xfer_cycle[0]), 32'd2);
    check_value("b_blocking_in_valid", 32'(valid_seen[3] - seen_before), 32'd0);
endtask

task automatic direct_path_b_to_a();
    int seen_before;
    seen_before = valid_seen[0];
    q_src_b_dir.push_back(random_direct());
    wait_drained();
    check_value("a_blocking_in latency", 32'(deliver_cycle[1] - xfer_cycle[3]), 32'd2);
    check_value("a_neighbor_in_valid", 32'(valid_seen[0] - seen_before), 32'd0);
endtask

task automatic neighbor_priority();
    q_src_a_nb.push_back(random_neighbor());
    q_src_a_dir.push_back(random_direct());
    wait_drained();
    check_value("a_blocking_out transfer order", 32'(xfer_cycle[1] - xfer_cycle[0]), 32'd1);
    check_value("b_blocking_in_valid rise", 32'(rise_cycle[3] - rise_cycle[2]), 32'd1);
endtask

task automatic backpressure_order();
    int count_before;
    count_before = xfer_count[0];
    sink_ready[2] = 1'b0;
    repeat (40) q_src_a_nb.push_back(random_neighbor());
    do @(negedge clk);
    while (out_ready[0]);
    check_value("a_neighbor_out transfers", 32'(xfer_count[0] - count_before), 32'd32);
    @(posedge clk);
    sink_ready[2] = 1'b1;
    wait_drained();
endtask

task automatic mixed_traffic_drain();
    logic [31:0] r;
    stall_en = 1'b1;
    // sources fill at random so the two kinds interleave on the link
    repeat (120) begin
        r = $random(seed);
        if (r[0]) q_src_a_nb.push_back(random_neighbor());
        if (r[1]) q_src_a_dir.push_back(random_direct());
        if (r[2]) q_src_b_nb.push_back(random_neighbor());
        if (r[3]) q_src_b_dir.push_back(random_direct());
        @(posedge clk);
    end
    do @(negedge clk);
    while (pending_words() > 0);
    @(negedge clk);
    check_value("has_flying_messages", 32'(has_flying_messages), 32'h0);
    stall_en = 1'b0;
    @(posedge clk);
endtask

//--- dv/tb_pu_link.sv
`timescale 1ns/1ps

module tb_pu_link
    import qdec_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 3000;  // tests need about 1200

    logic          clk = 1'b0;
    logic          rst_n = 1'b0;
    neighbor_msg_t a_nb_out = '0;
    neighbor_msg_t b_nb_out = '0;
    direct_msg_t   a_dir_out = '0;
    direct_msg_t   b_dir_out = '0;
    neighbor_msg_t a_nb_in;
    neighbor_msg_t b_nb_in;
    direct_msg_t   a_dir_in;
    direct_msg_t   b_dir_in;
    logic [3:0]    out_valid = '0;  // 0 a nb, 1 a dir, 2 b nb, 3 b dir
    logic [3:0]    out_ready;
    logic [3:0]    in_valid;        // sinks, same order
    logic [3:0]    in_ready = '1;
    logic [3:0]    sink_ready = '1;
    logic [3:0]    prev_in_valid = '0;
    logic          stall_en = 1'b0;
    logic          has_flying_messages;
    int            seed = 9048;
    int            cycle = 0;
    int            xfer_count[4] = '{default: 0};
    int            xfer_cycle[4] = '{default: 0};
    int            deliver_cycle[4] = '{default: 0};
    int            rise_cycle[4] = '{default: 0};
    int            valid_seen[4] = '{default: 0};

    neighbor_msg_t q_src_a_nb[$];
    neighbor_msg_t q_src_b_nb[$];
    neighbor_msg_t q_exp_a_nb[$];
    neighbor_msg_t q_exp_b_nb[$];
    direct_msg_t   q_src_a_dir[$];
    direct_msg_t   q_src_b_dir[$];
    direct_msg_t   q_exp_a_dir[$];
    direct_msg_t   q_exp_b_dir[$];

    pu_link_top pu_link_top_inst (
        .clk (clk), .rst_n (rst_n),
        .a_neighbor_out_data (a_nb_out), .a_neighbor_out_valid (out_valid[0]),
        .a_neighbor_out_ready (out_ready[0]),
        .a_blocking_out_data (a_dir_out), .a_blocking_out_valid (out_valid[1]),
        .a_blocking_out_ready (out_ready[1]),
        .a_neighbor_in_data (a_nb_in), .a_neighbor_in_valid (in_valid[0]),
        .a_neighbor_in_ready (in_ready[0]),
        .a_blocking_in_data (a_dir_in), .a_blocking_in_valid (in_valid[1]),
        .a_blocking_in_ready (in_ready[1]),
        .b_neighbor_out_data (b_nb_out), .b_neighbor_out_valid (out_valid[2]),
        .b_neighbor_out_ready (out_ready[2]),
        .b_blocking_out_data (b_dir_out), .b_blocking_out_valid (out_valid[3]),
        .b_blocking_out_ready (out_ready[3]),
        .b_neighbor_in_data (b_nb_in), .b_neighbor_in_valid (in_valid[2]),
        .b_neighbor_in_ready (in_ready[2]),
        .b_blocking_in_data (b_dir_in), .b_blocking_in_valid (in_valid[3]),
        .b_blocking_in_ready (in_ready[3]),
        .has_flying_messages (has_flying_messages)
    );

    `include "tb_pu_link_tasks.svh"

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout waiting for link to drain");
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // sources present their queue head, sinks stall at random when enabled
    always @(posedge clk) begin
        #1;
        out_valid = {q_src_b_dir.size() > 0, q_src_b_nb.size() > 0,
                     q_src_a_dir.size() > 0, q_src_a_nb.size() > 0};
        a_nb_out  = (q_src_a_nb.size() > 0) ? q_src_a_nb[0] : '0;
        a_dir_out = (q_src_a_dir.size() > 0) ? q_src_a_dir[0] : '0;
        b_nb_out  = (q_src_b_nb.size() > 0) ? q_src_b_nb[0] : '0;
        b_dir_out = (q_src_b_dir.size() > 0) ? q_src_b_dir[0] : '0;
        in_ready  = stall_en ? (sink_ready & 4'($random(seed))) : sink_ready;
    end

    // ********************
    // transfers are judged at negedge, where everything is settled
    // ********************
    always @(negedge clk) begin
        // a queued word is either at a source or inside the link
        if (pending_words() > 0) begin
            check_value("has_flying_messages", 32'(has_flying_messages), 32'h1);
        end
        for (int i = 0; i < 4; i++) begin
            if (in_valid[i]) valid_seen[i]++;
            if (in_valid[i] && !prev_in_valid[i]) rise_cycle[i] = cycle;
            if (out_valid[i] && out_ready[i]) begin
                xfer_count[i]++;
                xfer_cycle[i] = cycle + 1;  // edge that takes the word
            end
        end
        prev_in_valid = in_valid;
        if (out_valid[0] && out_ready[0]) q_exp_b_nb.push_back(q_src_a_nb.pop_front());
        if (out_valid[1] && out_ready[1]) q_exp_b_dir.push_back(q_src_a_dir.pop_front());
        if (out_valid[2] && out_ready[2]) q_exp_a_nb.push_back(q_src_b_nb.pop_front());
        if (out_valid[3] && out_ready[3]) q_exp_a_dir.push_back(q_src_b_dir.pop_front());
        if (in_valid[0] && in_ready[0]) begin
            if (q_exp_a_nb.size() == 0) fail_now("word on a_neighbor_in that nobody sent");
            else check_value("a_neighbor_in_data", 32'(q_exp_a_nb.pop_front()), 32'(a_nb_in));
            deliver_cycle[0] = cycle + 1;
        end
        if (in_valid[1] && in_ready[1]) begin
            if (q_exp_a_dir.size() == 0) fail_now("word on a_blocking_in that nobody sent");
            else check_value("a_blocking_in_data", 32'(q_exp_a_dir.pop_front()), 32'(a_dir_in));
            deliver_cycle[1] = cycle + 1;
        end
        if (in_valid[2] && in_ready[2]) begin
            if (q_exp_b_nb.size() == 0) fail_now("word on b_neighbor_in that nobody sent");
            else check_value("b_neighbor_in_data", 32'(q_exp_b_nb.pop_front()), 32'(b_nb_in));
            deliver_cycle[2] = cycle + 1;
        end
        if (in_valid[3] && in_ready[3]) begin
            if (q_exp_b_dir.size() == 0) fail_now("word on b_blocking_in that nobody sent");
            else check_value("b_blocking_in_data", 32'(q_exp_b_dir.pop_front()), 32'(b_dir_in));
            deliver_cycle[3] = cycle + 1;
        end
    end

    initial begin
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        reset_outputs_quiet();
        neighbor_path_a_to_b();
        direct_path_b_to_a();
        neighbor_priority();
        backpressure_order();
        mixed_traffic_drain();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- logic/pu_link_top.sv
`timescale 1ns/1ps

module pu_link_top
    import qdec_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // ********************
    // side a
    // ********************
    input  neighbor_msg_t a_neighbor_out_data,
    input  logic          a_neighbor_out_valid,
    output logic          a_neighbor_out_ready,
    input  direct_msg_t   a_blocking_out_data,
    input  logic          a_blocking_out_valid,
    output logic          a_blocking_out_ready,
    output neighbor_msg_t a_neighbor_in_data,
    output logic          a_neighbor_in_valid,
    input  logic          a_neighbor_in_ready,
    output direct_msg_t   a_blocking_in_data,
    output logic          a_blocking_in_valid,
    input  logic          a_blocking_in_ready,

    // ********************
    // side b
    // ********************
    input  neighbor_msg_t b_neighbor_out_data,
    input  logic          b_neighbor_out_valid,
    output logic          b_neighbor_out_ready,
    input  direct_msg_t   b_blocking_out_data,
    input  logic          b_blocking_out_valid,
    output logic          b_blocking_out_ready,
    output neighbor_msg_t b_neighbor_in_data,
    output logic          b_neighbor_in_valid,
    input  logic          b_neighbor_in_ready,
    output direct_msg_t   b_blocking_in_data,
    output logic          b_blocking_in_valid,
    input  logic          b_blocking_in_ready,

    output logic          has_flying_messages
);

    master_word_t a_to_b_data;
    logic         a_to_b_valid;
    logic         a_to_b_ready;
    master_word_t b_to_a_data;
    logic         b_to_a_valid;
    logic         b_to_a_ready;
    logic         a_flying;
    logic         b_flying;

    pu_arbitration_unit unit_a (
        .clk                 (clk),
        .rst_n               (rst_n),
        .neighbor_out_data   (a_neighbor_out_data),
        .neighbor_out_valid  (a_neighbor_out_valid),
        .neighbor_out_ready  (a_neighbor_out_ready),
        .blocking_out_data   (a_blocking_out_data),
        .blocking_out_valid  (a_blocking_out_valid),
        .blocking_out_ready  (a_blocking_out_ready),
        .neighbor_in_data    (a_neighbor_in_data),
        .neighbor_in_valid   (a_neighbor_in_valid),
        .neighbor_in_ready   (a_neighbor_in_ready),
        .blocking_in_data    (a_blocking_in_data),
        .blocking_in_valid   (a_blocking_in_valid),
        .blocking_in_ready   (a_blocking_in_ready),
        .master_out_data     (a_to_b_data),
        .master_out_valid    (a_to_b_valid),
        .master_out_ready    (a_to_b_ready),
        .master_in_data      (b_to_a_data),
        .master_in_valid     (b_to_a_valid),
        .master_in_ready     (b_to_a_ready),
        .has_flying_messages (a_flying)
    );

    pu_arbitration_unit unit_b (
        .clk                 (clk),
        .rst_n               (rst_n),
        .neighbor_out_data   (b_neighbor_out_data),
        .neighbor_out_valid  (b_neighbor_out_valid),
        .neighbor_out_ready  (b_neighbor_out_ready),
        .blocking_out_data   (b_blocking_out_data),
        .blocking_out_valid  (b_blocking_out_valid),
        .blocking_out_ready  (b_blocking_out_ready),
        .neighbor_in_data    (b_neighbor_in_data),
        .neighbor_in_valid   (b_neighbor_in_valid),
        .neighbor_in_ready   (b_neighbor_in_ready),
        .blocking_in_data    (b_blocking_in_data),
        .blocking_in_valid   (b_blocking_in_valid),
        .blocking_in_ready   (b_blocking_in_ready),
        .master_out_data     (b_to_a_data),
        .master_out_valid    (b_to_a_valid),
        .master_out_ready    (b_to_a_ready),
        .master_in_data      (a_to_b_data),
        .master_in_valid     (a_to_b_valid),
        .master_in_ready     (a_to_b_ready),
        .has_flying_messages (b_flying)
    );

    // words parked between the units show up as valid on both flags
    assign has_flying_messages = a_flying || b_flying;

endmodule

//--- logic/pu_arbitration_unit.sv
`timescale 1ns/1ps

module pu_arbitration_unit
    import qdec_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    input  neighbor_msg_t neighbor_out_data,
    input  logic          neighbor_out_valid,
    output logic          neighbor_out_ready,

    input  direct_msg_t   blocking_out_data,
    input  logic          blocking_out_valid,
    output logic          blocking_out_ready,

    output neighbor_msg_t neighbor_in_data,
    output logic          neighbor_in_valid,
    input  logic          neighbor_in_ready,

    output direct_msg_t   blocking_in_data,
    output logic          blocking_in_valid,
    input  logic          blocking_in_ready,

    output master_word_t  master_out_data,
    output logic          master_out_valid,
    input  logic          master_out_ready,

    input  master_word_t  master_in_data,
    input  logic          master_in_valid,
    output logic          master_in_ready,

    output logic          has_flying_messages
);

    master_word_t out_din;
    logic         out_wr_en;
    logic         out_full;
    logic         out_empty;

    master_word_t in_head;
    logic         in_rd_en;
    logic         in_full;
    logic         in_empty;

    // ********************
    // send side
    // ********************

    // neighbor wins whenever both sources are valid
    assign neighbor_out_ready = !out_full;
    assign blocking_out_ready = !out_full && !neighbor_out_valid;
    assign out_wr_en          = !out_full && (neighbor_out_valid || blocking_out_valid);

    always_comb begin
        out_din                    = '0;
        out_din.kind               = KIND_DIRECT;
        out_din.payload.direct.msg = blocking_out_data;
        if (neighbor_out_valid) begin
            out_din                      = '0;  // clears the wider direct field
            out_din.kind                 = KIND_NEIGHBOR;
            out_din.payload.neighbor.msg = neighbor_out_data;
        end
    end

    fifo_fwft #(
        .WIDTH (MASTER_FIFO_WIDTH),
        .DEPTH (LINK_FIFO_DEPTH)
    ) out_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (out_wr_en),
        .din   (out_din),
        .rd_en (master_out_ready && !out_empty),
        .dout  (master_out_data),
        .full  (out_full),
        .empty (out_empty)
    );

    assign master_out_valid = !out_empty;

    // ********************
    // receive side
    // ********************

    assign master_in_ready = !in_full;

    fifo_fwft #(
        .WIDTH (MASTER_FIFO_WIDTH),
        .DEPTH (LINK_FIFO_DEPTH)
    ) in_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (master_in_valid && !in_full),
        .din   (master_in_data),
        .rd_en (in_rd_en),
        .dout  (in_head),
        .full  (in_full),
        .empty (in_empty)
    );

    assign neighbor_in_data = in_head.payload.neighbor.msg;
    assign blocking_in_data = in_head.payload.direct.msg;

    // head goes to exactly one sink, popped when that sink takes it
    always_comb begin
        neighbor_in_valid = 1'b0;
        blocking_in_valid = 1'b0;
        in_rd_en          = 1'b0;
        if (!in_empty) begin
            case (in_head.kind)
                KIND_NEIGHBOR: begin
                    neighbor_in_valid = 1'b1;
                    in_rd_en          = neighbor_in_ready;
                end
                KIND_DIRECT: begin
                    blocking_in_valid = 1'b1;
                    in_rd_en          = blocking_in_ready;
                end
                default: ;  // illegal tag, held at head
            endcase
        end
    end

    assign has_flying_messages = neighbor_out_valid || blocking_out_valid ||
                                 neighbor_in_valid  || blocking_in_valid  ||
                                 master_out_valid   || master_in_valid;

    // sending unit zero-fills the payload bits its kind leaves unused
    a_zero_pad : assert property (
        @(posedge clk) disable iff (!rst_n)
        !in_empty |-> ((in_head.kind == KIND_NEIGHBOR) ?
                       (in_head.payload.neighbor.pad == '0) :
                       (in_head.payload.direct.pad == '0))
    ) else $error("nonzero pad bits at in_fifo head");

    // far side only ever writes the two legal tags
    a_legal_kind : assert property (
        @(posedge clk) disable iff (!rst_n)
        !in_empty |-> (in_head.kind == KIND_NEIGHBOR || in_head.kind == KIND_DIRECT)
    ) else $error("illegal kind tag at in_fifo head");

endmodule

//--- logic/fifo_fwft.sv
`timescale 1ns/1ps

module fifo_fwft
    import qdec_pkg::*;
#(
    parameter int WIDTH = MASTER_FIFO_WIDTH,
    parameter int DEPTH = LINK_FIFO_DEPTH  // power of two
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [$clog2(DEPTH):0] wr_ptr;  // top bit is the wrap flag
    logic [$clog2(DEPTH):0] rd_ptr;
    logic                   push;
    logic                   pop;

    assign push = wr_en && !full;
    assign pop  = rd_en && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                   (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);

    // head word falls through with no read latency
    assign dout = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    // ********************
    // storage and pointers
    // ********************

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ********************
    // usage checks
    // ********************

    // the writer must watch full, the reader must watch empty
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        full |-> !wr_en
    ) else $error("fifo_fwft write while full");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        empty |-> !rd_en
    ) else $error("fifo_fwft read while empty");

endmodule

//--- logic/qdec_pkg.sv
package qdec_pkg;

    // ********************
    // code geometry
    // ********************

    localparam int CODE_DISTANCE_X = 5;
    localparam int CODE_DISTANCE_Z = 4;

    // larger of the two distances sets the round count
    localparam int MEASUREMENT_ROUNDS = (CODE_DISTANCE_X > CODE_DISTANCE_Z) ?
                                        CODE_DISTANCE_X : CODE_DISTANCE_Z;

    localparam int PER_DIMENSION_WIDTH = $clog2(MEASUREMENT_ROUNDS);
    localparam int ADDRESS_WIDTH       = PER_DIMENSION_WIDTH * 3;  // x, z, round

    // ********************
    // message widths
    // ********************

    localparam int DIRECT_MESSAGE_WIDTH = ADDRESS_WIDTH + 1 + 1;
    localparam int UNION_MESSAGE_WIDTH  = 2 * ADDRESS_WIDTH;       // old root + new root
    localparam int MASTER_FIFO_WIDTH    = UNION_MESSAGE_WIDTH + 2;  // kind tag on top

    localparam int LINK_FIFO_DEPTH = 16;

    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] address;
        logic                     extra;  // rides along with the neighbor address
    } neighbor_msg_t;

    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] receiver;
        logic                     is_odd_cardinality_root;
        logic                     is_touching_boundary;
    } direct_msg_t;

    // 00 and 11 keep the two kinds at full hamming distance
    typedef enum logic [1:0] {
        KIND_NEIGHBOR = 2'b00,
        KIND_DIRECT   = 2'b11
    } msg_kind_e;

    typedef struct packed {
        logic [UNION_MESSAGE_WIDTH-ADDRESS_WIDTH-2:0] pad;
        neighbor_msg_t                                msg;
    } neighbor_view_t;

    typedef struct packed {
        logic [UNION_MESSAGE_WIDTH-DIRECT_MESSAGE_WIDTH-1:0] pad;
        direct_msg_t                                         msg;
    } direct_view_t;

    // one payload word, read according to the kind tag
    typedef union packed {
        neighbor_view_t neighbor;
        direct_view_t   direct;
    } master_payload_u;

    typedef struct packed {
        msg_kind_e       kind;
        master_payload_u payload;
    } master_word_t;

endpackage
